//--- source/beam_pkg.sv
package beam_pkg;

	////////////////////
	// Array geometry
	localparam int NUM_ELEMENTS = 256;
	localparam int ELEM_ADDR_W  = 8;
	localparam logic [ELEM_ADDR_W-1:0] LAST_ELEM_ADDR = ELEM_ADDR_W'(NUM_ELEMENTS - 1);

	////////////////////
	// Offset and delay widths
	localparam int OFFSET_W = 5;
	localparam int DELAY_W  = 5;
	// Moves the offset range -16..15 onto 0..31
	localparam logic [DELAY_W-1:0] DELAY_BIAS = 5'd16;

	typedef enum logic [1:0] {SCAN_IDLE, SCAN_RUN} scan_state_t;

endpackage

//--- source/steer_offset_rom.sv
`timescale 1ns/100ps

module steer_offset_rom (
	input  logic [beam_pkg::ELEM_ADDR_W-1:0] a,
	output logic [beam_pkg::OFFSET_W-1:0]    spo
);

	// Row in a[7:4], column in a[3:0], signed offsets in two's complement
	always_comb begin
		case (a)
			8'd0:   spo = 5'h0b;
			8'd1:   spo = 5'h0b;
			8'd2:   spo = 5'h0a;
			8'd3:   spo = 5'h09;
			8'd4:   spo = 5'h09;
			8'd5:   spo = 5'h08;
			8'd6:   spo = 5'h07;
			8'd7:   spo = 5'h07;
			8'd8:   spo = 5'h06;
			8'd9:   spo = 5'h05;
			8'd10:  spo = 5'h05;
			8'd11:  spo = 5'h04;
			8'd12:  spo = 5'h04;
			8'd13:  spo = 5'h03;
			8'd14:  spo = 5'h02;
			8'd15:  spo = 5'h02;
			8'd16:  spo = 5'h0b;
			8'd17:  spo = 5'h0a;
			8'd18:  spo = 5'h09;
			8'd19:  spo = 5'h09;
			8'd20:  spo = 5'h08;
			8'd21:  spo = 5'h07;
			8'd22:  spo = 5'h07;
			8'd23:  spo = 5'h06;
			8'd24:  spo = 5'h05;
			8'd25:  spo = 5'h05;
			8'd26:  spo = 5'h04;
			8'd27:  spo = 5'h03;
			8'd28:  spo = 5'h03;
			8'd29:  spo = 5'h02;
			8'd30:  spo = 5'h02;
			8'd31:  spo = 5'h01;
			8'd32:  spo = 5'h0a;
			8'd33:  spo = 5'h09;
			8'd34:  spo = 5'h08;
			8'd35:  spo = 5'h08;
			8'd36:  spo = 5'h07;
			8'd37:  spo = 5'h07;
			8'd38:  spo = 5'h06;
			8'd39:  spo = 5'h05;
			8'd40:  spo = 5'h05;
			8'd41:  spo = 5'h04;
			8'd42:  spo = 5'h03;
			8'd43:  spo = 5'h03;
			8'd44:  spo = 5'h02;
			8'd45:  spo = 5'h01;
			8'd46:  spo = 5'h01;
			8'd47:  spo = 5'h00;
			8'd48:  spo = 5'h09;
			8'd49:  spo = 5'h08;
			8'd50:  spo = 5'h08;
			8'd51:  spo = 5'h07;
			8'd52:  spo = 5'h06;
			8'd53:  spo = 5'h06;
			8'd54:  spo = 5'h05;
			8'd55:  spo = 5'h04;
			8'd56:  spo = 5'h04;
			8'd57:  spo = 5'h03;
			8'd58:  spo = 5'h03;
			8'd59:  spo = 5'h02;
			8'd60:  spo = 5'h01;
			8'd61:  spo = 5'h01;
			8'd62:  spo = 5'h00;
			8'd63:  spo = 5'h1f;
			8'd64:  spo = 5'h08;
			8'd65:  spo = 5'h08;
			8'd66:  spo = 5'h07;
			8'd67:  spo = 5'h06;
			8'd68:  spo = 5'h06;
			8'd69:  spo = 5'h05;
			8'd70:  spo = 5'h04;
			8'd71:  spo = 5'h04;
			8'd72:  spo = 5'h03;
			8'd73:  spo = 5'h02;
			8'd74:  spo = 5'h02;
			8'd75:  spo = 5'h01;
			8'd76:  spo = 5'h00;
			8'd77:  spo = 5'h00;
			8'd78:  spo = 5'h1f;
			8'd79:  spo = 5'h1f;
			8'd80:  spo = 5'h07;
			8'd81:  spo = 5'h07;
			8'd82:  spo = 5'h06;
			8'd83:  spo = 5'h06;
			8'd84:  spo = 5'h05;
			8'd85:  spo = 5'h04;
			8'd86:  spo = 5'h04;
			8'd87:  spo = 5'h03;
			8'd88:  spo = 5'h02;
			8'd89:  spo = 5'h02;
			8'd90:  spo = 5'h01;
			8'd91:  spo = 5'h00;
			8'd92:  spo = 5'h00;
			8'd93:  spo = 5'h1f;
			8'd94:  spo = 5'h1e;
			8'd95:  spo = 5'h1e;
			8'd96:  spo = 5'h07;
			8'd97:  spo = 5'h06;
			8'd98:  spo = 5'h05;
			8'd99:  spo = 5'h05;
			8'd100: spo = 5'h04;
			8'd101: spo = 5'h03;
			8'd102: spo = 5'h03;
			8'd103: spo = 5'h02;
			8'd104: spo = 5'h02;
			8'd105: spo = 5'h01;
			8'd106: spo = 5'h00;
			8'd107: spo = 5'h00;
			8'd108: spo = 5'h1f;
			8'd109: spo = 5'h1e;
			8'd110: spo = 5'h1e;
			8'd111: spo = 5'h1d;
			8'd112: spo = 5'h06;
			8'd113: spo = 5'h05;
			8'd114: spo = 5'h05;
			8'd115: spo = 5'h04;
			8'd116: spo = 5'h03;
			8'd117: spo = 5'h03;
			8'd118: spo = 5'h02;
			8'd119: spo = 5'h01;
			8'd120: spo = 5'h01;
			8'd121: spo = 5'h00;
			8'd122: spo = 5'h1f;
			8'd123: spo = 5'h1f;
			8'd124: spo = 5'h1e;
			8'd125: spo = 5'h1e;
			8'd126: spo = 5'h1d;
			8'd127: spo = 5'h1c;
			8'd128: spo = 5'h05;
			8'd129: spo = 5'h04;
			8'd130: spo = 5'h04;
			8'd131: spo = 5'h03;
			8'd132: spo = 5'h03;
			8'd133: spo = 5'h02;
			8'd134: spo = 5'h01;
			8'd135: spo = 5'h01;
			8'd136: spo = 5'h00;
			8'd137: spo = 5'h1f;
			8'd138: spo = 5'h1f;
			8'd139: spo = 5'h1e;
			8'd140: spo = 5'h1d;
			8'd141: spo = 5'h1d;
			8'd142: spo = 5'h1c;
			8'd143: spo = 5'h1c;
			8'd144: spo = 5'h04;
			8'd145: spo = 5'h04;
			8'd146: spo = 5'h03;
			8'd147: spo = 5'h02;
			8'd148: spo = 5'h02;
			8'd149: spo = 5'h01;
			8'd150: spo = 5'h01;
			8'd151: spo = 5'h00;
			8'd152: spo = 5'h1f;
			8'd153: spo = 5'h1f;
			8'd154: spo = 5'h1e;
			8'd155: spo = 5'h1d;
			8'd156: spo = 5'h1d;
			8'd157: spo = 5'h1c;
			8'd158: spo = 5'h1b;
			8'd159: spo = 5'h1b;
			8'd160: spo = 5'h04;
			8'd161: spo = 5'h03;
			8'd162: spo = 5'h02;
			8'd163: spo = 5'h02;
			8'd164: spo = 5'h01;
			8'd165: spo = 5'h00;
			8'd166: spo = 5'h00;
			8'd167: spo = 5'h1f;
			8'd168: spo = 5'h1e;
			8'd169: spo = 5'h1e;
			8'd170: spo = 5'h1d;
			8'd171: spo = 5'h1d;
			8'd172: spo = 5'h1c;
			8'd173: spo = 5'h1b;
			8'd174: spo = 5'h1b;
			8'd175: spo = 5'h1a;
			8'd176: spo = 5'h03;
			8'd177: spo = 5'h02;
			8'd178: spo = 5'h02;
			8'd179: spo = 5'h01;
			8'd180: spo = 5'h00;
			8'd181: spo = 5'h00;
			8'd182: spo = 5'h1f;
			8'd183: spo = 5'h1e;
			8'd184: spo = 5'h1e;
			8'd185: spo = 5'h1d;
			8'd186: spo = 5'h1c;
			8'd187: spo = 5'h1c;
			8'd188: spo = 5'h1b;
			8'd189: spo = 5'h1a;
			8'd190: spo = 5'h1a;
			8'd191: spo = 5'h19;
			8'd192: spo = 5'h02;
			8'd193: spo = 5'h01;
			8'd194: spo = 5'h01;
			8'd195: spo = 5'h00;
			8'd196: spo = 5'h00;
			8'd197: spo = 5'h1f;
			8'd198: spo = 5'h1e;
			8'd199: spo = 5'h1e;
			8'd200: spo = 5'h1d;
			8'd201: spo = 5'h1c;
			8'd202: spo = 5'h1c;
			8'd203: spo = 5'h1b;
			8'd204: spo = 5'h1a;
			8'd205: spo = 5'h1a;
			8'd206: spo = 5'h19;
			8'd207: spo = 5'h18;
			8'd208: spo = 5'h01;
			8'd209: spo = 5'h01;
			8'd210: spo = 5'h00;
			8'd211: spo = 5'h1f;
			8'd212: spo = 5'h1f;
			8'd213: spo = 5'h1e;
			8'd214: spo = 5'h1d;
			8'd215: spo = 5'h1d;
			8'd216: spo = 5'h1c;
			8'd217: spo = 5'h1c;
			8'd218: spo = 5'h1b;
			8'd219: spo = 5'h1a;
			8'd220: spo = 5'h1a;
			8'd221: spo = 5'h19;
			8'd222: spo = 5'h18;
			8'd223: spo = 5'h18;
			8'd224: spo = 5'h01;
			8'd225: spo = 5'h00;
			8'd226: spo = 5'h1f;
			8'd227: spo = 5'h1f;
			8'd228: spo = 5'h1e;
			8'd229: spo = 5'h1d;
			8'd230: spo = 5'h1d;
			8'd231: spo = 5'h1c;
			8'd232: spo = 5'h1b;
			8'd233: spo = 5'h1b;
			8'd234: spo = 5'h1a;
			8'd235: spo = 5'h19;
			8'd236: spo = 5'h19;
			8'd237: spo = 5'h18;
			8'd238: spo = 5'h18;
			8'd239: spo = 5'h17;
			8'd240: spo = 5'h00;
			8'd241: spo = 5'h1f;
			8'd242: spo = 5'h1e;
			8'd243: spo = 5'h1e;
			8'd244: spo = 5'h1d;
			8'd245: spo = 5'h1d;
			8'd246: spo = 5'h1c;
			8'd247: spo = 5'h1b;
			8'd248: spo = 5'h1b;
			8'd249: spo = 5'h1a;
			8'd250: spo = 5'h19;
			8'd251: spo = 5'h19;
			8'd252: spo = 5'h18;
			8'd253: spo = 5'h17;
			8'd254: spo = 5'h17;
			8'd255: spo = 5'h16;
			default: spo = 5'h00;
		endcase
	end

endmodule

//--- source/element_scanner.sv
`timescale 1ns/100ps

module element_scanner (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            start,
	output logic                            busy,
	output logic [beam_pkg::ELEM_ADDR_W-1:0] elem_addr,
	output logic                            addr_valid
);

	beam_pkg::scan_state_t state;

	assign busy = (state == beam_pkg::SCAN_RUN);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= beam_pkg::SCAN_IDLE;
			elem_addr  <= '0;
			addr_valid <= 1'b0;
		end else begin
			case (state)
				beam_pkg::SCAN_IDLE: begin
					// start while busy never reaches this branch
					if (start) begin
						state      <= beam_pkg::SCAN_RUN;
						elem_addr  <= '0;
						addr_valid <= 1'b1;
					end
				end
				beam_pkg::SCAN_RUN: begin
					if (elem_addr == beam_pkg::LAST_ELEM_ADDR) begin
						state      <= beam_pkg::SCAN_IDLE;
						addr_valid <= 1'b0;
					end else begin
						elem_addr <= elem_addr + 8'd1;
					end
				end
				default: state <= beam_pkg::SCAN_IDLE;
			endcase
		end
	end

endmodule

//--- source/delay_mapper.sv
`timescale 1ns/100ps

module delay_mapper (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             addr_valid,
	input  logic [beam_pkg::ELEM_ADDR_W-1:0] elem_addr,
	input  logic [beam_pkg::OFFSET_W-1:0]    offset,
	output logic                             elem_valid,
	output logic [beam_pkg::ELEM_ADDR_W-1:0] elem_index,
	output logic [beam_pkg::DELAY_W-1:0]     elem_delay,
	output logic [beam_pkg::DELAY_W-1:0]     min_delay,
	output logic [beam_pkg::DELAY_W-1:0]     max_delay,
	output logic                             done
);

	logic [beam_pkg::DELAY_W-1:0] delay_next;
	logic                         first_elem;
	logic                         last_elem;

	// Same as sign extension then bias, result always in 0..31
	assign delay_next = offset + beam_pkg::DELAY_BIAS;
	assign first_elem = (elem_addr == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			elem_valid <= 1'b0;
			elem_index <= '0;
			elem_delay <= '0;
			min_delay  <= '0;
			max_delay  <= '0;
			last_elem  <= 1'b0;
			done       <= 1'b0;
		end else begin
			elem_valid <= addr_valid;
			last_elem  <= addr_valid && (elem_addr == beam_pkg::LAST_ELEM_ADDR);
			done       <= last_elem;
			if (addr_valid) begin
				elem_index <= elem_addr;
				elem_delay <= delay_next;
				// Extremes restart at element 0 of each scan
				if (first_elem || delay_next < min_delay) begin
					min_delay <= delay_next;
				end
				if (first_elem || delay_next > max_delay) begin
					max_delay <= delay_next;
				end
			end
		end
	end

endmodule

//--- source/beam_delay_planner.sv
`timescale 1ns/100ps

module beam_delay_planner (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             start,
	output logic                             busy,
	output logic                             elem_valid,
	output logic [beam_pkg::ELEM_ADDR_W-1:0] elem_index,
	output logic [beam_pkg::DELAY_W-1:0]     elem_delay,
	output logic [beam_pkg::DELAY_W-1:0]     min_delay,
	output logic [beam_pkg::DELAY_W-1:0]     max_delay,
	output logic                             done
);

	logic [beam_pkg::ELEM_ADDR_W-1:0] elem_addr;
	logic                             addr_valid;
	logic [beam_pkg::OFFSET_W-1:0]    offset;

	////////////////////
	// Address walk
	element_scanner u_scanner (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.busy       (busy),
		.elem_addr  (elem_addr),
		.addr_valid (addr_valid)
	);

	steer_offset_rom u_rom (
		.a   (elem_addr),
		.spo (offset)
	);

	////////////////////
	// Delays and extremes
	delay_mapper u_mapper (
		.clk        (clk),
		.rst_n      (rst_n),
		.addr_valid (addr_valid),
		.elem_addr  (elem_addr),
		.offset     (offset),
		.elem_valid (elem_valid),
		.elem_index (elem_index),
		.elem_delay (elem_delay),
		.min_delay  (min_delay),
		.max_delay  (max_delay),
		.done       (done)
	);

endmodule

//--- tb/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
	output logic clk
);

	localparam time HALF_PERIOD = 5ns;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

//--- tb/beam_delay_planner_asserts.sv
`timescale 1ns/100ps

module beam_delay_planner_asserts (
	input logic                             clk,
	input logic                             rst_n,
	input logic                             busy,
	input logic                             elem_valid,
	input logic [beam_pkg::ELEM_ADDR_W-1:0] elem_index,
	input logic                             done
);

	int failures = 0;

	// Last element leaves the mapper on the cycle busy falls
	strobe_inside_scan: assert property (@(posedge clk) disable iff (!rst_n)
		elem_valid && !busy |-> elem_index == beam_pkg::LAST_ELEM_ADDR)
	else begin
		$error("elem_valid outside a scan at index %0d", elem_index);
		failures++;
	end

	done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
		done |=> !done)
	else begin
		$error("done held high for more than one cycle");
		failures++;
	end

	index_steps_by_one: assert property (@(posedge clk) disable iff (!rst_n)
		elem_valid |=> !elem_valid || elem_index == $past(elem_index) + 8'd1)
	else begin
		$error("elem_index did not step by one between strobes");
		failures++;
	end

endmodule

bind beam_delay_planner beam_delay_planner_asserts u_asserts (
	.clk        (clk),
	.rst_n      (rst_n),
	.busy       (busy),
	.elem_valid (elem_valid),
	.elem_index (elem_index),
	.done       (done)
);

//--- tb/beam_delay_planner_tb.sv
`timescale 1ns/100ps

module beam_delay_planner_tb;

	localparam int NUM_SPOTS         = 13;
	localparam int NUM_SCANS         = 4;
	localparam int RESET_CYCLES      = 5;
	localparam int FIRST_VALID_CYCLE = 2;
	localparam int DONE_CYCLE        = 258;
	localparam int POKE_CYCLE        = 100;
	localparam int MAX_GAP           = 16;
	localparam int WATCHDOG_CYCLES   =
		RESET_CYCLES + NUM_SCANS * (DONE_CYCLE + 2 + MAX_GAP) + 200;

	logic                             clk;
	logic                             rst_n;
	logic                             start;
	logic                             busy;
	logic                             elem_valid;
	logic [beam_pkg::ELEM_ADDR_W-1:0] elem_index;
	logic [beam_pkg::DELAY_W-1:0]     elem_delay;
	logic [beam_pkg::DELAY_W-1:0]     min_delay;
	logic [beam_pkg::DELAY_W-1:0]     max_delay;
	logic                             done;

	// Index and delay pairs followed by the extremes
	logic [7:0]  pat_mem [0:2*NUM_SPOTS+1];
	int          exp_delay [0:beam_pkg::NUM_ELEMENTS-1];
	int          exp_min;
	int          exp_max;
	int          errors;
	int          strobes_checked;
	int          gap;
	logic [31:0] rng_state;

	tb_clock_gen u_clk (
		.clk (clk)
	);

	beam_delay_planner uut (
		.clk        (clk),
		.rst_n      (rst_n),
		.start      (start),
		.busy       (busy),
		.elem_valid (elem_valid),
		.elem_index (elem_index),
		.elem_delay (elem_delay),
		.min_delay  (min_delay),
		.max_delay  (max_delay),
		.done       (done)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic report_mismatch(input string signal_name, input int expected, input int actual);
		$display("FAILED at %0t: %s expected %0d, actual %0d",
			$time, signal_name, expected, actual);
		errors++;
	endtask

	task automatic report_problem(input string what);
		$display("ERROR at %0t: %s", $time, what);
		errors++;
	endtask

	task automatic load_patterns();
		for (int i = 0; i < beam_pkg::NUM_ELEMENTS; i++) begin
			exp_delay[i] = -1;
		end
		$readmemh("tb/beam_patterns.txt", pat_mem);
		for (int i = 0; i < NUM_SPOTS; i++) begin
			exp_delay[pat_mem[2*i]] = int'(pat_mem[2*i+1]);
		end
		exp_min = int'(pat_mem[2*NUM_SPOTS]);
		exp_max = int'(pat_mem[2*NUM_SPOTS+1]);
	endtask

	////////////////////
	// One scan with cycles counted from the edge that samples start
	task automatic run_scan(input int scan_no, input bit poke_busy);
		int cyc;
		int strobes;
		int spots;
		bit finished;
		cyc = 0;
		strobes = 0;
		spots = 0;
		finished = 1'b0;
		@(posedge clk);
		start <= 1'b1;
		while (!finished && cyc < DONE_CYCLE + 8) begin
			@(posedge clk);
			// Extra start pulse lands while the scan is busy
			start <= poke_busy && cyc == POKE_CYCLE;
			@(negedge clk);
			cyc++;
			if (cyc == 1 && busy !== 1'b1) begin
				report_mismatch("busy", 1, int'(busy));
			end
			if (elem_valid === 1'b1) begin
				if (strobes == 0 && cyc != FIRST_VALID_CYCLE) begin
					report_mismatch("first elem_valid cycle", FIRST_VALID_CYCLE, cyc);
				end
				if (int'(elem_index) != strobes) begin
					report_mismatch("elem_index", strobes, int'(elem_index));
				end
				if (exp_delay[elem_index] >= 0) begin
					spots++;
					if (int'(elem_delay) != exp_delay[elem_index]) begin
						report_mismatch("elem_delay", exp_delay[elem_index], int'(elem_delay));
					end
				end
				strobes++;
			end
			if (done === 1'b1) begin
				finished = 1'b1;
				if (cyc != DONE_CYCLE) begin
					report_mismatch("done cycle", DONE_CYCLE, cyc);
				end
				if (strobes != beam_pkg::NUM_ELEMENTS) begin
					report_mismatch("elem_valid count", beam_pkg::NUM_ELEMENTS, strobes);
				end
				if (int'(min_delay) != exp_min) begin
					report_mismatch("min_delay", exp_min, int'(min_delay));
				end
				if (int'(max_delay) != exp_max) begin
					report_mismatch("max_delay", exp_max, int'(max_delay));
				end
				if (busy !== 1'b0) begin
					report_mismatch("busy", 0, int'(busy));
				end
				if (spots != NUM_SPOTS) begin
					report_mismatch("spot checks seen", NUM_SPOTS, spots);
				end
			end
		end
		if (!finished) begin
			report_problem($sformatf("scan %0d never raised done", scan_no));
		end
		strobes_checked += strobes;
	endtask

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: scans did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		start = 1'b0;
		errors = 0;
		strobes_checked = 0;
		rng_state = 32'd59;
		load_patterns();
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);

		// Idle outputs after reset
		if (busy !== 1'b0) begin
			report_mismatch("busy", 0, int'(busy));
		end
		if (elem_valid !== 1'b0) begin
			report_mismatch("elem_valid", 0, int'(elem_valid));
		end
		if (done !== 1'b0) begin
			report_mismatch("done", 0, int'(done));
		end
		if (min_delay !== '0) begin
			report_mismatch("min_delay", 0, int'(min_delay));
		end
		if (max_delay !== '0) begin
			report_mismatch("max_delay", 0, int'(max_delay));
		end

		run_scan(0, 1'b1);
		for (int s = 1; s < NUM_SCANS; s++) begin
			rng_state = xorshift32(rng_state);
			gap = int'(rng_state[3:0]) + 1;
			repeat (gap) @(posedge clk);
			run_scan(s, 1'b0);
		end

		if (uut.u_asserts.failures != 0) begin
			report_problem($sformatf("%0d assertion failures", uut.u_asserts.failures));
		end
		$display("Scans: %0d, strobes checked: %0d, errors: %0d",
			NUM_SCANS, strobes_checked, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- tb/beam_patterns.txt
// Columns: element index, expected delay (hex), one pair per line
// Last line: expected minimum and maximum delay of a scan
00 1b
0f 12
10 1b
2f 10
3f 0f
4f 0f
64 14
7f 0c
80 15
af 0a
c8 0d
f0 10
ff 06
06 1b

//--- compile.f
source/beam_pkg.sv
source/steer_offset_rom.sv
source/element_scanner.sv
source/delay_mapper.sv
source/beam_delay_planner.sv
tb/tb_clock_gen.sv
tb/beam_delay_planner_asserts.sv
tb/beam_delay_planner_tb.sv

//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f compile.f --top-module beam_delay_planner_tb -o sim_beam

run: compile
	-./obj_dir/sim_beam +verilator+error+limit+1000 > sim.log 2>&1
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TEST PASSED" sim.log || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
